/* source/wb_com_cfg.svh */
// --------------------------------------
// Wishbone commutator configuration
// Bus widths, queue size and time tag
// --------------------------------------

`ifndef WB_COM_CFG_SVH
`define WB_COM_CFG_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// Request queue address size, depth is 2**ASIZE
`define WB_FIFO_ASIZE 2

// Time tag is two bits wider than the queue address
`define WB_TAG_W (`WB_FIFO_ASIZE + 2)

// Outstanding slave requests, half the tag range
`define WB_MAX_OUT (1 << (`WB_TAG_W - 1))

`endif

/* source/wb_com_pkg.sv */
// --------------------------------------
// Wishbone commutator types
// Bus vectors and queue entry structs
// --------------------------------------

`include "wb_com_cfg.svh"

package wb_com_pkg;

  // --------------------------------------
  // Bus vectors
  // --------------------------------------
  typedef logic [`WB_ADDR_W-1:0]   wb_addr_t;
  typedef logic [`WB_DATA_W-1:0]   wb_data_t;
  typedef logic [`WB_DATA_W/8-1:0] wb_sel_t;

  // Arrival time of a request
  typedef logic [`WB_TAG_W-1:0]    wb_tag_t;

  // --------------------------------------
  // Queue entries
  // --------------------------------------

  // Request as queued by a master port
  typedef struct packed {
    wb_addr_t addr;
    wb_sel_t  sel;
    logic     we;
    wb_tag_t  tag;
    wb_data_t dat;
  } wb_req_t;

  // Response as queued by the slave port
  typedef struct packed {
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

/* source/wb_com_fifo.sv */
// --------------------------------------
// Show-ahead synchronous FIFO
// Head word visible while not empty
// --------------------------------------

module wb_com_fifo #(
  parameter int WIDTH = 8,
  parameter int ASIZE = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] wr_data_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] rd_data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int DEPTH = 1 << ASIZE;

  logic [WIDTH-1:0] mem [DEPTH];

  // Extra top bit tells full from empty
  logic [ASIZE:0]   wr_ptr;
  logic [ASIZE:0]   rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en_i & ~full_o;
  assign do_rd = rd_en_i & ~empty_o;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[ASIZE] != rd_ptr[ASIZE]) &&
                   (wr_ptr[ASIZE-1:0] == rd_ptr[ASIZE-1:0]);

  // Head of queue
  assign rd_data_o = mem[rd_ptr[ASIZE-1:0]];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[ASIZE-1:0]] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

/* source/wb_com_master.sv */
// --------------------------------------
// Wishbone commutator master port
// Tags and queues requests, returns
// queued responses as ack or err
// --------------------------------------

`include "wb_com_cfg.svh"

module wb_com_master (
  input  logic                clk,
  input  logic                rst,

  // Pipelined Wishbone from the master
  input  logic                m_cyc_i,
  input  logic                m_stb_i,
  input  logic                m_we_i,
  input  wb_com_pkg::wb_addr_t m_addr_i,
  input  wb_com_pkg::wb_sel_t  m_sel_i,
  input  wb_com_pkg::wb_data_t m_dat_i,
  output logic                m_stall_o,
  output logic                m_ack_o,
  output logic                m_err_o,
  output wb_com_pkg::wb_data_t m_dat_o,

  // Request queue head towards the slave port
  output wb_com_pkg::wb_req_t req_o,
  output logic                req_empty_o,
  input  logic                req_rden_i,

  // Response queue head from the slave port
  input  wb_com_pkg::wb_rsp_t rsp_i,
  input  logic                rsp_empty_i,
  output logic                rsp_rden_o
);

  import wb_com_pkg::*;

  wb_tag_t  tag_cnt;
  wb_req_t  req_in;
  logic     req_full;
  logic     accept;
  logic     ack_q;
  logic     err_q;
  wb_data_t dat_q;

  // --------------------------------------
  // Time tag
  // --------------------------------------

  // Runs in step with the other master port
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_cnt <= '0;
    end else begin
      tag_cnt <= tag_cnt + 1'b1;
    end
  end

  // --------------------------------------
  // Request side
  // --------------------------------------
  assign m_stall_o = req_full;
  assign accept    = m_cyc_i & m_stb_i & ~req_full;

  assign req_in = '{
    addr: m_addr_i,
    sel:  m_sel_i,
    we:   m_we_i,
    tag:  tag_cnt,
    dat:  m_dat_i
  };

  wb_com_fifo #(
    .WIDTH ($bits(wb_req_t)),
    .ASIZE (`WB_FIFO_ASIZE)
  ) req_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (accept),
    .wr_data_i (req_in),
    .rd_en_i   (req_rden_i),
    .rd_data_o (req_o),
    .full_o    (req_full),
    .empty_o   (req_empty_o)
  );

  // --------------------------------------
  // Response side
  // --------------------------------------

  // Drain one response per cycle
  assign rsp_rden_o = ~rsp_empty_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= rsp_rden_o & ~rsp_i.err;
      err_q <= rsp_rden_o & rsp_i.err;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_rden_o) begin
      dat_q <= rsp_i.dat;
    end
  end

  assign m_ack_o = ack_q;
  assign m_err_o = err_q;
  assign m_dat_o = dat_q;

endmodule

/* source/wb_com_slave.sv */
// --------------------------------------
// Wishbone commutator slave port
// Age arbitration between two masters,
// issue on the slave bus, response routing
// --------------------------------------

`include "wb_com_cfg.svh"

module wb_com_slave (
  input  logic                 clk,
  input  logic                 rst,

  // Pipelined Wishbone towards the slave
  output logic                 s_cyc_o,
  output logic                 s_stb_o,
  output logic                 s_we_o,
  output wb_com_pkg::wb_addr_t s_addr_o,
  output wb_com_pkg::wb_sel_t  s_sel_o,
  output wb_com_pkg::wb_data_t s_dat_o,
  input  wb_com_pkg::wb_data_t s_dat_i,
  input  logic                 s_stall_i,
  input  logic                 s_ack_i,
  input  logic                 s_err_i,

  // Request queue heads
  input  wb_com_pkg::wb_req_t  m0_req_i,
  input  logic                 m0_req_empty_i,
  output logic                 m0_req_rden_o,
  input  wb_com_pkg::wb_req_t  m1_req_i,
  input  logic                 m1_req_empty_i,
  output logic                 m1_req_rden_o,

  // Response queue heads
  output wb_com_pkg::wb_rsp_t  m0_rsp_o,
  output logic                 m0_rsp_empty_o,
  input  logic                 m0_rsp_rden_i,
  output wb_com_pkg::wb_rsp_t  m1_rsp_o,
  output logic                 m1_rsp_empty_o,
  input  logic                 m1_rsp_rden_i
);

  import wb_com_pkg::*;

  localparam int MAX_OUT = `WB_MAX_OUT;
  localparam int TW      = `WB_TAG_W;

  wb_tag_t              m0_tag;
  wb_tag_t              m1_tag;
  logic                 m1_dir;
  wb_req_t              sel_req;
  logic                 issue;
  logic                 rsp_in;
  logic                 has_out;
  logic                 m1_owner;
  logic [MAX_OUT-1:0]   dir_sr;
  logic [MAX_OUT-1:0]   occ;
  wb_rsp_t              rsp_word;
  logic                 m0_rsp_wr;
  logic                 m1_rsp_wr;

  // --------------------------------------
  // Age arbitration
  // --------------------------------------
  assign m0_tag = m0_req_i.tag;
  assign m1_tag = m1_req_i.tag;

  // Top bits differ when the counter wrapped between the two arrivals
  assign m1_dir = m0_req_empty_i |
                  (~m1_req_empty_i &
                   ((m1_tag[TW-1] ^ m0_tag[TW-1]) ?
                    (m1_tag[TW-2:0] > m0_tag[TW-2:0]) :
                    (m1_tag[TW-2:0] < m0_tag[TW-2:0])));

  assign sel_req = m1_dir ? m1_req_i : m0_req_i;

  // --------------------------------------
  // Slave bus request
  // --------------------------------------
  assign has_out = |occ;
  assign s_stb_o = (~m0_req_empty_i | ~m1_req_empty_i) & ~occ[MAX_OUT-1];
  assign s_cyc_o = ~m0_req_empty_i | ~m1_req_empty_i | has_out;
  assign s_we_o   = sel_req.we;
  assign s_addr_o = sel_req.addr;
  assign s_sel_o  = sel_req.sel;
  assign s_dat_o  = sel_req.dat;

  assign issue         = s_stb_o & ~s_stall_i;
  assign m0_req_rden_o = issue & ~m1_dir;
  assign m1_req_rden_o = issue & m1_dir;

  // --------------------------------------
  // Outstanding request tracking
  // --------------------------------------

  // Newest direction enters at bit 0, occ marks the oldest one
  assign rsp_in = s_ack_i | s_err_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      dir_sr <= '0;
      occ    <= '0;
    end else begin
      if (issue) begin
        dir_sr <= {dir_sr[MAX_OUT-2:0], m1_dir};
      end
      if (issue && !rsp_in) begin
        occ <= has_out ? (occ << 1) : {{(MAX_OUT-1){1'b0}}, 1'b1};
      end else if (rsp_in && !issue) begin
        occ <= occ >> 1;
      end
    end
  end

  // Nothing outstanding means the answer is for the request now issued
  assign m1_owner  = has_out ? |(occ & dir_sr) : m1_dir;
  assign m0_rsp_wr = rsp_in & (has_out | issue) & ~m1_owner;
  assign m1_rsp_wr = rsp_in & (has_out | issue) & m1_owner;

  assign rsp_word = '{err: s_err_i, dat: s_dat_i};

  // --------------------------------------
  // Response queues
  // --------------------------------------
  wb_com_fifo #(
    .WIDTH ($bits(wb_rsp_t)),
    .ASIZE (`WB_FIFO_ASIZE + 1)
  ) m0_rsp_fifo_inst (
    .clk (clk), .rst (rst),
    .wr_en_i (m0_rsp_wr), .wr_data_i (rsp_word),
    .rd_en_i (m0_rsp_rden_i), .rd_data_o (m0_rsp_o),
    .full_o (), .empty_o (m0_rsp_empty_o)
  );

  wb_com_fifo #(
    .WIDTH ($bits(wb_rsp_t)),
    .ASIZE (`WB_FIFO_ASIZE + 1)
  ) m1_rsp_fifo_inst (
    .clk (clk), .rst (rst),
    .wr_en_i (m1_rsp_wr), .wr_data_i (rsp_word),
    .rd_en_i (m1_rsp_rden_i), .rd_data_o (m1_rsp_o),
    .full_o (), .empty_o (m1_rsp_empty_o)
  );

endmodule

/* source/wb_com_top.sv */
// --------------------------------------
// Wishbone commutator top level
// Two master ports sharing one slave
// --------------------------------------

module wb_com_top (
  input  logic                 clk,
  input  logic                 rst,

  // Master 0
  input  logic                 m0_cyc_i,
  input  logic                 m0_stb_i,
  input  logic                 m0_we_i,
  input  wb_com_pkg::wb_addr_t m0_addr_i,
  input  wb_com_pkg::wb_sel_t  m0_sel_i,
  input  wb_com_pkg::wb_data_t m0_dat_i,
  output logic                 m0_stall_o,
  output logic                 m0_ack_o,
  output logic                 m0_err_o,
  output wb_com_pkg::wb_data_t m0_dat_o,

  // Master 1
  input  logic                 m1_cyc_i,
  input  logic                 m1_stb_i,
  input  logic                 m1_we_i,
  input  wb_com_pkg::wb_addr_t m1_addr_i,
  input  wb_com_pkg::wb_sel_t  m1_sel_i,
  input  wb_com_pkg::wb_data_t m1_dat_i,
  output logic                 m1_stall_o,
  output logic                 m1_ack_o,
  output logic                 m1_err_o,
  output wb_com_pkg::wb_data_t m1_dat_o,

  // Shared slave
  output logic                 s_cyc_o,
  output logic                 s_stb_o,
  output logic                 s_we_o,
  output wb_com_pkg::wb_addr_t s_addr_o,
  output wb_com_pkg::wb_sel_t  s_sel_o,
  output wb_com_pkg::wb_data_t s_dat_o,
  input  wb_com_pkg::wb_data_t s_dat_i,
  input  logic                 s_stall_i,
  input  logic                 s_ack_i,
  input  logic                 s_err_i
);

  import wb_com_pkg::*;

  wb_req_t m0_req;
  wb_req_t m1_req;
  wb_rsp_t m0_rsp;
  wb_rsp_t m1_rsp;
  logic    m0_req_empty;
  logic    m1_req_empty;
  logic    m0_req_rden;
  logic    m1_req_rden;
  logic    m0_rsp_empty;
  logic    m1_rsp_empty;
  logic    m0_rsp_rden;
  logic    m1_rsp_rden;

  // --------------------------------------
  // Master ports
  // --------------------------------------
  wb_com_master m0_port_inst (
    .clk (clk), .rst (rst),
    .m_cyc_i (m0_cyc_i), .m_stb_i (m0_stb_i), .m_we_i (m0_we_i),
    .m_addr_i (m0_addr_i), .m_sel_i (m0_sel_i), .m_dat_i (m0_dat_i),
    .m_stall_o (m0_stall_o), .m_ack_o (m0_ack_o), .m_err_o (m0_err_o),
    .m_dat_o (m0_dat_o),
    .req_o (m0_req), .req_empty_o (m0_req_empty), .req_rden_i (m0_req_rden),
    .rsp_i (m0_rsp), .rsp_empty_i (m0_rsp_empty), .rsp_rden_o (m0_rsp_rden)
  );

  wb_com_master m1_port_inst (
    .clk (clk), .rst (rst),
    .m_cyc_i (m1_cyc_i), .m_stb_i (m1_stb_i), .m_we_i (m1_we_i),
    .m_addr_i (m1_addr_i), .m_sel_i (m1_sel_i), .m_dat_i (m1_dat_i),
    .m_stall_o (m1_stall_o), .m_ack_o (m1_ack_o), .m_err_o (m1_err_o),
    .m_dat_o (m1_dat_o),
    .req_o (m1_req), .req_empty_o (m1_req_empty), .req_rden_i (m1_req_rden),
    .rsp_i (m1_rsp), .rsp_empty_i (m1_rsp_empty), .rsp_rden_o (m1_rsp_rden)
  );

  // --------------------------------------
  // Slave port
  // --------------------------------------
  wb_com_slave slave_port_inst (
    .clk (clk), .rst (rst),
    .s_cyc_o (s_cyc_o), .s_stb_o (s_stb_o), .s_we_o (s_we_o),
    .s_addr_o (s_addr_o), .s_sel_o (s_sel_o), .s_dat_o (s_dat_o),
    .s_dat_i (s_dat_i), .s_stall_i (s_stall_i),
    .s_ack_i (s_ack_i), .s_err_i (s_err_i),
    .m0_req_i (m0_req), .m0_req_empty_i (m0_req_empty), .m0_req_rden_o (m0_req_rden),
    .m1_req_i (m1_req), .m1_req_empty_i (m1_req_empty), .m1_req_rden_o (m1_req_rden),
    .m0_rsp_o (m0_rsp), .m0_rsp_empty_o (m0_rsp_empty), .m0_rsp_rden_i (m0_rsp_rden),
    .m1_rsp_o (m1_rsp), .m1_rsp_empty_o (m1_rsp_empty), .m1_rsp_rden_i (m1_rsp_rden)
  );

endmodule

/* verification/wb_slave_model.sv */
// --------------------------------------
// Behavioral Wishbone memory slave
// Random stall and ack delay, err when
// the top address bit is set
// --------------------------------------

module wb_slave_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hold_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  wb_com_pkg::wb_addr_t addr_i,
  input  wb_com_pkg::wb_sel_t  sel_i,
  input  wb_com_pkg::wb_data_t dat_i,
  output logic                 stall_o,
  output logic                 ack_o,
  output logic                 err_o,
  output wb_com_pkg::wb_data_t dat_o
);

  import wb_com_pkg::*;

  wb_data_t mem [256];
  wb_rsp_t  pend_rsp [$];
  int       pend_due [$];
  int       cycle;
  wb_data_t word;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      stall_o <= 1'b0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      dat_o   <= '0;
      cycle = 0;
      pend_rsp.delete();
      pend_due.delete();
    end else begin
      cycle = cycle + 1;
      stall_o <= hold_i | ($urandom % 4 == 0);
      // Transfer seen with the stall of the current cycle
      if (cyc_i && stb_i && !stall_o) begin
        if (addr_i[31]) begin
          pend_rsp.push_back('{err: 1'b1, dat: '0});
        end else begin
          word = mem[addr_i[9:2]];
          for (int b = 0; b < 4; b++) begin
            if (we_i && sel_i[b]) begin
              word[8*b +: 8] = dat_i[8*b +: 8];
            end
          end
          mem[addr_i[9:2]] = word;
          pend_rsp.push_back('{err: 1'b0, dat: word});
        end
        pend_due.push_back(cycle + int'($urandom % 4));
      end
      ack_o <= 1'b0;
      err_o <= 1'b0;
      // In order, one response per cycle
      if (pend_rsp.size() != 0 && pend_due[0] <= cycle) begin
        ack_o <= ~pend_rsp[0].err;
        err_o <= pend_rsp[0].err;
        dat_o <= pend_rsp[0].dat;
        void'(pend_rsp.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

endmodule

/* verification/wb_com_tb.sv */
// --------------------------------------
// Wishbone commutator testbench
// Directed tests on two masters and a
// memory slave model
// --------------------------------------

`include "wb_com_cfg.svh"

module wb_com_tb;

  import wb_com_pkg::*;

  localparam int MAX_REQ = 32;
  localparam int N_REQ   = 48;
  localparam int AGE_WIN = 1 << (`WB_TAG_W - 1);

  logic     clk;
  logic     rst;
  logic     m_cyc [2];
  logic     m_stb [2];
  logic     m_we [2];
  wb_addr_t m_addr [2];
  wb_sel_t  m_sel [2];
  wb_data_t m_dat_w [2];
  logic     m_stall [2];
  logic     m_ack [2];
  logic     m_err [2];
  wb_data_t m_dat_r [2];
  logic     s_cyc;
  logic     s_stb;
  logic     s_we;
  wb_addr_t s_addr;
  wb_sel_t  s_sel;
  wb_data_t s_dat_w;
  wb_data_t s_dat_r;
  logic     s_stall;
  logic     s_ack;
  logic     s_err;
  logic     hold;

  // Request lists and expected responses, per master
  wb_addr_t req_addr [2][MAX_REQ];
  logic     req_we [2][MAX_REQ];
  wb_data_t req_dat [2][MAX_REQ];
  logic     exp_err [2][MAX_REQ];
  wb_data_t exp_dat [2][MAX_REQ];
  wb_data_t shadow [256];
  int       req_n [2];
  int       base [2];

  // Observed by the monitor
  wb_data_t rsp_dat [2][MAX_REQ];
  logic     rsp_err [2][MAX_REQ];
  int       acc_cyc [2][MAX_REQ];
  int       rsp_n [2];
  int       acc_n [2];
  int       iss_n [2];
  int       s_rsp_n;
  logic     last_stall [2];
  int       cycle = 0;

  wb_com_top wb_com_top_inst (
    .clk (clk), .rst (rst),
    .m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]), .m0_we_i (m_we[0]),
    .m0_addr_i (m_addr[0]), .m0_sel_i (m_sel[0]), .m0_dat_i (m_dat_w[0]),
    .m0_stall_o (m_stall[0]), .m0_ack_o (m_ack[0]), .m0_err_o (m_err[0]),
    .m0_dat_o (m_dat_r[0]),
    .m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]), .m1_we_i (m_we[1]),
    .m1_addr_i (m_addr[1]), .m1_sel_i (m_sel[1]), .m1_dat_i (m_dat_w[1]),
    .m1_stall_o (m_stall[1]), .m1_ack_o (m_ack[1]), .m1_err_o (m_err[1]),
    .m1_dat_o (m_dat_r[1]),
    .s_cyc_o (s_cyc), .s_stb_o (s_stb), .s_we_o (s_we), .s_addr_o (s_addr),
    .s_sel_o (s_sel), .s_dat_o (s_dat_w), .s_dat_i (s_dat_r),
    .s_stall_i (s_stall), .s_ack_i (s_ack), .s_err_i (s_err)
  );

  wb_slave_model slave_model_inst (
    .clk (clk), .rst (rst), .hold_i (hold),
    .cyc_i (s_cyc), .stb_i (s_stb), .we_i (s_we), .addr_i (s_addr),
    .sel_i (s_sel), .dat_i (s_dat_w), .stall_o (s_stall),
    .ack_o (s_ack), .err_o (s_err), .dat_o (s_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------------------------
  // Failure and compare tasks
  // --------------------------------------
  task automatic stop_on_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_on_error("data compare failed");
    end
  endtask

  task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_on_error("slave bus order wrong");
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
      stop_on_error("err flag compare failed");
    end
  endtask

  task automatic check_cyc(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
      stop_on_error("slave cycle flag compare failed");
    end
  endtask

  // --------------------------------------
  // Monitor, sampled at the falling edge
  // --------------------------------------
  always @(negedge clk) begin
    int m;
    int o;
    int k;
    int j;
    if (!rst) begin
      // Cycle stays open while a request is queued or awaits its answer
      check_cyc("s_cyc_o", s_cyc, (acc_n[0] + acc_n[1]) != s_rsp_n);
      if (s_ack || s_err) begin
        s_rsp_n = s_rsp_n + 1;
      end
      if (s_stb && !s_stall) begin
        m = int'(s_addr[8]);
        o = 1 - m;
        k = iss_n[m];
        j = iss_n[o];
        if (k >= req_n[m]) stop_on_error("slave request with no matching master request");
        check_addr($sformatf("s_addr m%0d[%0d]", m, k), s_addr, req_addr[m][k]);
        // Older request of the other master must not be overtaken
        if (j < acc_n[o] && acc_cyc[o][j] < acc_cyc[m][k] &&
            cycle - acc_cyc[o][j] < AGE_WIN) begin
          stop_on_error("an older request was issued after a younger one");
        end
        iss_n[m] = k + 1;
      end
      for (int i = 0; i < 2; i++) begin
        last_stall[i] = m_stall[i];
        if (m_cyc[i] && m_stb[i] && !m_stall[i]) begin
          acc_cyc[i][acc_n[i]] = cycle;
          acc_n[i] = acc_n[i] + 1;
        end
        if (m_ack[i] || m_err[i]) begin
          if (rsp_n[i] >= req_n[i]) stop_on_error("response with no request pending");
          rsp_dat[i][rsp_n[i]] = m_dat_r[i];
          rsp_err[i][rsp_n[i]] = m_err[i];
          rsp_n[i] = rsp_n[i] + 1;
        end
      end
    end
  end

  // --------------------------------------
  // Master driver tasks
  // --------------------------------------
  task automatic add_request(input int m, input logic we, input wb_addr_t addr);
    int n;
    n = req_n[m];
    req_addr[m][n] = addr;
    req_we[m][n]   = we;
    req_dat[m][n]  = $urandom;
    exp_err[m][n]  = addr[31];
    exp_dat[m][n]  = shadow[addr[9:2]];
    if (we && !addr[31]) begin
      shadow[addr[9:2]] = req_dat[m][n];
    end
    req_n[m] = n + 1;
  endtask

  task automatic issue_requests(input int m);
    int   i;
    logic taken;
    i = base[m];
    @(posedge clk);
    while (i < req_n[m]) begin
      m_cyc[m]   <= 1'b1;
      m_stb[m]   <= 1'b1;
      m_we[m]    <= req_we[m][i];
      m_addr[m]  <= req_addr[m][i];
      m_sel[m]   <= '1;
      m_dat_w[m] <= req_dat[m][i];
      @(negedge clk);
      taken = ~m_stall[m];
      @(posedge clk);
      if (taken) i = i + 1;
    end
    m_stb[m] <= 1'b0;
  endtask

  task automatic finish_and_check();
    while (rsp_n[0] != req_n[0] || rsp_n[1] != req_n[1]) @(posedge clk);
    m_cyc[0] <= 1'b0;
    m_cyc[1] <= 1'b0;
    repeat (8) @(posedge clk);
    for (int m = 0; m < 2; m++) begin
      for (int i = base[m]; i < req_n[m]; i++) begin
        check_err($sformatf("m%0d_err[%0d]", m, i), rsp_err[m][i], exp_err[m][i]);
        if (!req_we[m][i] && !exp_err[m][i]) begin
          check_data($sformatf("m%0d_dat[%0d]", m, i), rsp_dat[m][i], exp_dat[m][i]);
        end
      end
      base[m] = req_n[m];
    end
  endtask

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic test_single();
    for (int m = 0; m < 2; m++) begin
      add_request(m, 1'b1, 32'h10 + 32'h100 * m);
      add_request(m, 1'b0, 32'h10 + 32'h100 * m);
      issue_requests(m);
      finish_and_check();
    end
  endtask

  task automatic test_interleaved(input wb_addr_t err_addr, input int pairs);
    for (int i = 0; i < pairs; i++) begin
      add_request(0, 1'b1, (i == 0) ? err_addr : 32'h20 + 4 * i);
      add_request(0, 1'b0, (i == 0) ? err_addr : 32'h20 + 4 * i);
      add_request(1, 1'b1, 32'h120 + 4 * i);
      add_request(1, 1'b0, 32'h120 + 4 * i);
    end
    fork
      issue_requests(0);
      issue_requests(1);
    join
    finish_and_check();
  endtask

  task automatic test_age();
    for (int i = 0; i < 4; i++) begin
      add_request(0, 1'b0, 32'h20 + 4 * i);
      add_request(1, 1'b0, 32'h120 + 4 * i);
    end
    fork
      issue_requests(0);
      begin
        @(posedge clk);
        issue_requests(1);
      end
    join
    finish_and_check();
  endtask

  task automatic test_backpressure();
    for (int i = 0; i < 6; i++) begin
      add_request(0, i < 3, 32'h60 + 4 * (i % 3));
      add_request(1, i < 3, 32'h160 + 4 * (i % 3));
    end
    hold <= 1'b1;
    repeat (2) @(posedge clk);
    fork
      issue_requests(0);
      issue_requests(1);
      begin
        repeat (20) @(posedge clk);
        for (int m = 0; m < 2; m++) begin
          if (!last_stall[m] || acc_n[m] - base[m] != 4) begin
            stop_on_error($sformatf("master %0d stall not raised with 4 queued", m));
          end
        end
        hold <= 1'b0;
      end
    join
    finish_and_check();
  endtask

  // Limit from the total number of requests
  initial begin
    repeat (16 + 200 * N_REQ) @(posedge clk);
    stop_on_error("watchdog timeout, responses did not arrive");
  end

  initial begin
    void'($urandom(32'h2c5e_fe61));
    rst  = 1'b1;
    hold = 1'b0;
    for (int m = 0; m < 2; m++) begin
      m_cyc[m]   = 1'b0;
      m_stb[m]   = 1'b0;
      m_we[m]    = 1'b0;
      m_addr[m]  = '0;
      m_sel[m]   = '0;
      m_dat_w[m] = '0;
      req_n[m]   = 0;
      base[m]    = 0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_single();
    test_interleaved(32'h20, 4);
    test_interleaved(32'h8000_0040, 2);
    test_age();
    test_backpressure();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/wb_com_pkg.sv
source/wb_com_fifo.sv
source/wb_com_master.sv
source/wb_com_slave.sv
source/wb_com_top.sv
verification/wb_slave_model.sv
verification/wb_com_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wb_com_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= filelist.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) source/wb_com_cfg.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
